// File: vlog.f
design/cache_geom_pkg.sv
design/cache_bus_pkg.sv
design/cache_store.sv
design/cache_fsm.sv
design/cache_top.sv
tests/slow_mem.sv
tests/cache_tb.sv

// File: Bender.yml
package:
  name: cache_2way

sources:
  - target: rtl
    files:
      - design/cache_geom_pkg.sv
      - design/cache_bus_pkg.sv
      - design/cache_store.sv
      - design/cache_fsm.sv
      - design/cache_top.sv

  - target: test
    files:
      - tests/slow_mem.sv
      - tests/cache_tb.sv

// File: tests/cache_tb.sv
// single random requester on four tags per set; the flat model assumes slow_mem's address pattern
`default_nettype none

module cache_tb;
	import cache_geom_pkg::*;
	import cache_bus_pkg::*;

	localparam int NUM_SETS   = 4;
	localparam int IDX_W      = $clog2(NUM_SETS);
	localparam int NUM_REQ    = 400;
	localparam int WAIT_LIMIT = 200;  // cycles per request

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [$bits(line_addr_t)-IDX_W-1:0] tag_t;

	logic       clk;
	logic       rst_n;
	proc_req_t  proc_req;
	word_t      proc_rdata;
	logic       proc_stall;
	mem_req_t   mem_req;
	line_t      mem_rdata;
	logic       mem_ready;
	logic [2:0] ready_delay;
	int         wb_count;
	int         rd_count;
	line_addr_t wb_addr;
	line_t      wb_line;
	line_addr_t rd_addr;

	int          errors;
	int          checks;
	logic        hung;
	logic [31:0] lcg_state;
	mem_req_t    prev_req;
	logic        prev_wait;

	word_t flat [4*NUM_SETS*WORDS_PER_LINE];  // {pick, set, offset}

	// residency model
	logic [NUM_SETS-1:0][1:0] res_valid;
	logic [1:0]               res_pick [NUM_SETS][2];
	logic [NUM_SETS-1:0]      res_lru;

	cache_top #(.NUM_SETS(NUM_SETS)) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.proc_req   (proc_req),
		.proc_rdata (proc_rdata),
		.proc_stall (proc_stall),
		.mem_req    (mem_req),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	slow_mem mem_model (
		.clk         (clk),
		.rst_n       (rst_n),
		.mem_req     (mem_req),
		.ready_delay (ready_delay),
		.mem_rdata   (mem_rdata),
		.mem_ready   (mem_ready),
		.wb_count    (wb_count),
		.wb_addr     (wb_addr),
		.wb_line     (wb_line),
		.rd_count    (rd_count),
		.rd_addr     (rd_addr)
	);

	always #20 clk = ~clk;

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	function automatic tag_t tag_for(input logic [1:0] pick);
		case (pick)
			2'd0: return 'h0000005;
			2'd1: return 'h2000005;  // top bit only differs from pick 0
			2'd2: return 'h1234567;
			default: return 'h0abcdef;
		endcase
	endfunction

	function automatic line_addr_t line_for(input logic [1:0] pick, input idx_t set);
		return {tag_for(pick), set};
	endfunction

	function automatic int flat_index(input logic [1:0] pick, input idx_t set, input word_off_t off);
		return (int'(pick) * NUM_SETS + int'(set)) * WORDS_PER_LINE + int'(off);
	endfunction

	function automatic line_t flat_line(input logic [1:0] pick, input idx_t set);
		line_t l;
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			l[i*WORD_BITS +: WORD_BITS] = flat[flat_index(pick, set, word_off_t'(i))];
		end
		return l;
	endfunction

	task automatic check_value(input string name, input logic [159:0] got,
			input logic [159:0] exp);
		checks++;
		if (got !== exp) begin
			$display("** Error: %s is %0h, expected %0h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic check_idle_port();
		check_value("proc_stall", proc_stall, 1'b0);
		check_value("mem_req.read", mem_req.read, 1'b0);
		check_value("mem_req.write", mem_req.write, 1'b0);
	endtask

	// ------------------------------------------------------------------------
	// one random request, driven on the falling edge and checked at completion
	// ------------------------------------------------------------------------
	task automatic run_request();
		logic [15:0] r;
		logic [1:0]  pick;
		idx_t        set;
		word_off_t   off;
		logic        is_write;
		word_t       wdata;
		logic        resident;
		logic        way;
		logic        vic;
		int          wb_before;
		int          rd_before;
		int          n;
		int          w;
		r        = next_rand();
		pick     = r[1:0];
		set      = idx_t'(r[7:4]);
		off      = r[9:8];
		is_write = r[12];
		wdata    = {next_rand(), next_rand()};
		@(negedge clk);
		if (r[15:13] == 3'd0) begin  // idle cycle
			proc_req <= '0;
			@(posedge clk);
			check_idle_port();
			return;
		end
		resident = 1'b0;
		way      = 1'b0;
		for (w = 0; w < 2; w++) begin
			if (res_valid[set][w] && res_pick[set][w] == pick) begin
				resident = 1'b1;
				way      = w[0];
			end
		end
		if (!res_valid[set][0]) begin
			vic = 1'b0;
		end else if (!res_valid[set][1]) begin
			vic = 1'b1;
		end else begin
			vic = res_lru[set];
		end
		proc_req.read  <= !is_write;
		proc_req.write <= is_write;
		proc_req.addr  <= {line_for(pick, set), off};
		proc_req.wdata <= wdata;
		r = next_rand();
		ready_delay <= r[2:0];
		wb_before = wb_count;
		rd_before = rd_count;
		@(posedge clk);
		check_value("proc_stall", proc_stall, !resident);
		n = 0;
		while (proc_stall && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (proc_stall) begin
			$display("request to line %h did not complete within %0d cycles",
				line_for(pick, set), WAIT_LIMIT);
			errors++;
			hung = 1'b1;
			return;
		end
		if (!is_write) begin
			check_value("proc_rdata", proc_rdata, flat[flat_index(pick, set, off)]);
		end
		check_value("refill count", rd_count - rd_before, resident ? 0 : 1);
		check_value("write-back count", wb_count - wb_before,
			(!resident && res_valid[set][vic]) ? 1 : 0);
		if (!resident) begin
			check_value("refill mem_req.addr", rd_addr, line_for(pick, set));
			if (res_valid[set][vic]) begin  // LRU line leaves with current values
				check_value("write-back mem_req.addr", wb_addr, line_for(res_pick[set][vic], set));
				check_value("write-back mem_req.wdata", wb_line, flat_line(res_pick[set][vic], set));
			end
			res_valid[set][vic] = 1'b1;
			res_pick[set][vic]  = pick;
			way                 = vic;
		end
		res_lru[set] = ~way;
		if (is_write) begin
			flat[flat_index(pick, set, off)] = wdata;
		end
	endtask

	// ------------------------------------------------------------------------
	// memory port protocol
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			prev_wait = 1'b0;
		end else begin
			if (mem_req.read && mem_req.write) begin
				$display("memory read and write were requested together at %0t", $time);
				errors++;
			end
			if (prev_wait) begin
				check_value("mem_req", mem_req, prev_req);  // must hold until ready
			end
			prev_wait = (mem_req.read || mem_req.write) && !mem_ready;
			prev_req  = mem_req;
		end
	end

	initial begin
		int i;
		clk         = 1'b0;
		rst_n       = 1'b0;
		proc_req    = '0;
		ready_delay = '0;
		lcg_state   = 32'd16560;
		errors      = 0;
		checks      = 0;
		hung        = 1'b0;
		res_valid   = '0;
		res_lru     = '0;
		for (i = 0; i < 4 * NUM_SETS * WORDS_PER_LINE; i++) begin
			flat[i] = {line_for(i / (NUM_SETS * WORDS_PER_LINE), idx_t'(i / WORDS_PER_LINE)),
				word_off_t'(i)} ;
			flat[i] = {flat[i][29:0], 2'b11} ^ 32'h6b8e_31d5;  // slow_mem pattern
		end
		repeat (8) @(posedge clk);
		check_idle_port();
		@(negedge clk);
		rst_n = 1'b1;
		@(posedge clk);
		check_idle_port();
		for (i = 0; i < NUM_REQ && !hung; i++) begin
			run_request();
		end
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/slow_mem.sv
// simulation-only memory; unwritten lines read back an address pattern, ready comes on the falling edge
`default_nettype none

module slow_mem (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cache_bus_pkg::mem_req_t    mem_req,
	input  logic [2:0]                 ready_delay,  // wait cycles before ready
	output cache_geom_pkg::line_t      mem_rdata,
	output logic                       mem_ready,
	output int                         wb_count,
	output cache_geom_pkg::line_addr_t wb_addr,
	output cache_geom_pkg::line_t      wb_line,
	output int                         rd_count,
	output cache_geom_pkg::line_addr_t rd_addr
);
	import cache_geom_pkg::*;

	line_addr_t stored_addr [$];  // written lines only
	line_t      stored_line [$];
	int         wait_cnt;

	function automatic word_t pattern_word(input word_addr_t a);
		return {a, 2'b11} ^ 32'h6b8e_31d5;
	endfunction

	function automatic line_t read_line(input line_addr_t a);
		line_t l;
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			l[i*WORD_BITS +: WORD_BITS] = pattern_word({a, word_off_t'(i)});
		end
		foreach (stored_addr[j]) begin
			if (stored_addr[j] == a) begin
				l = stored_line[j];
			end
		end
		return l;
	endfunction

	task automatic write_line(input line_addr_t a, input line_t l);
		int found;
		found = -1;
		foreach (stored_addr[j]) begin
			if (stored_addr[j] == a) begin
				found = j;
			end
		end
		if (found < 0) begin
			stored_addr.push_back(a);
			stored_line.push_back(l);
		end else begin
			stored_line[found] = l;
		end
	endtask

	always @(negedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_ready <= 1'b0;
			mem_rdata <= '0;
			wait_cnt  <= 0;
			wb_count  <= 0;
			wb_addr   <= '0;
			wb_line   <= '0;
			rd_count  <= 0;
			rd_addr   <= '0;
		end else if (mem_ready) begin
			mem_ready <= 1'b0;  // one cycle only
			wait_cnt  <= 0;
		end else if (mem_req.read || mem_req.write) begin
			if (wait_cnt >= ready_delay) begin
				mem_ready <= 1'b1;
				if (mem_req.write) begin
					write_line(mem_req.addr, mem_req.wdata);
					wb_addr  <= mem_req.addr;
					wb_line  <= mem_req.wdata;
					wb_count <= wb_count + 1;
				end else begin
					mem_rdata <= read_line(mem_req.addr);
					rd_addr   <= mem_req.addr;
					rd_count  <= rd_count + 1;
				end
			end else begin
				wait_cnt <= wait_cnt + 1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/cache_top.sv
// two-way cache with write-back of every valid victim; hit data is combinational, misses stall
`default_nettype none

module cache_top #(
	parameter int NUM_SETS = 4  // power of two, at least 2
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_bus_pkg::proc_req_t proc_req,
	output cache_geom_pkg::word_t    proc_rdata,
	output logic                     proc_stall,
	output cache_bus_pkg::mem_req_t  mem_req,
	input  cache_geom_pkg::line_t    mem_rdata,
	input  logic                     mem_ready
);
	import cache_geom_pkg::*;

	// ------------------------------------------------------------------------
	// store to controller
	// ------------------------------------------------------------------------
	logic       hit;
	logic       victim_valid;
	line_addr_t victim_addr;
	line_t      victim_line;

	// controller to store
	logic access;
	logic fill;

	cache_store #(
		.NUM_SETS (NUM_SETS)
	) u_store (
		.clk          (clk),
		.rst_n        (rst_n),
		.proc_req     (proc_req),
		.proc_rdata   (proc_rdata),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_addr  (victim_addr),
		.victim_line  (victim_line),
		.access       (access),
		.fill         (fill),
		.mem_rdata    (mem_rdata)
	);

	cache_fsm #(
		.NUM_SETS (NUM_SETS)
	) u_fsm (
		.clk          (clk),
		.rst_n        (rst_n),
		.proc_req     (proc_req),
		.hit          (hit),
		.victim_valid (victim_valid),
		.victim_addr  (victim_addr),
		.victim_line  (victim_line),
		.mem_ready    (mem_ready),
		.access       (access),
		.fill         (fill),
		.proc_stall   (proc_stall),
		.mem_req      (mem_req)
	);

endmodule

`default_nettype wire

// File: design/cache_fsm.sv
// NUM_SETS must match cache_store; relies on the requester holding proc_req while stalled
`default_nettype none

module cache_fsm #(
	parameter int NUM_SETS = 4
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cache_bus_pkg::proc_req_t   proc_req,
	input  logic                       hit,
	input  logic                       victim_valid,
	input  cache_geom_pkg::line_addr_t victim_addr,
	input  cache_geom_pkg::line_t      victim_line,
	input  logic                       mem_ready,
	output logic                       access,
	output logic                       fill,
	output logic                       proc_stall,
	output cache_bus_pkg::mem_req_t    mem_req
);
	import cache_geom_pkg::*;

	typedef enum logic [1:0] {
		ST_READY,
		ST_WRITE_BACK,
		ST_REFILL
	} state_e;

	state_e     state_q;
	state_e     state_d;
	logic       req_present;
	line_addr_t req_line;

	assign req_present = proc_req.read | proc_req.write;
	assign req_line    = proc_req.addr[$bits(word_addr_t)-1:$bits(word_off_t)];

	// ------------------------------------------------------------------------
	// miss sequencing
	// ------------------------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_READY: begin
				if (req_present && !hit) begin
					state_d = victim_valid ? ST_WRITE_BACK : ST_REFILL;
				end
			end
			ST_WRITE_BACK: begin
				if (mem_ready) begin
					state_d = ST_REFILL;
				end
			end
			ST_REFILL: begin
				if (mem_ready) begin
					state_d = ST_READY;  // request hits on the next cycle
				end
			end
			default: begin
				state_d = ST_READY;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_READY;
		end else begin
			state_q <= state_d;
		end
	end

	// ------------------------------------------------------------------------
	// strobes and stall
	// ------------------------------------------------------------------------
	assign access     = (state_q == ST_READY) && req_present && hit;
	assign fill       = (state_q == ST_REFILL) && mem_ready;
	assign proc_stall = req_present && !access;  // low only on a served hit

	// memory request, a pure decode of state and held inputs
	always_comb begin
		mem_req      = '0;
		mem_req.addr = req_line;
		case (state_q)
			ST_WRITE_BACK: begin
				mem_req.write = 1'b1;
				mem_req.addr  = victim_addr;
				mem_req.wdata = victim_line;
			end
			ST_REFILL: begin
				mem_req.read = 1'b1;
			end
			default: begin
				mem_req.read = 1'b0;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	a_mem_rw_excl: assert property (
		@(posedge clk) disable iff (!rst_n) !(mem_req.read && mem_req.write)
	);

	// request must not move while memory is still busy with it
	a_mem_req_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		((mem_req.read || mem_req.write) && !mem_ready) |=> $stable(mem_req)
	);

endmodule

`default_nettype wire

// File: design/cache_store.sv
// NUM_SETS must be a power of two and at least 2; no dirty bits, every valid victim counts as dirty
`default_nettype none

module cache_store #(
	parameter int NUM_SETS = 4
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cache_bus_pkg::proc_req_t   proc_req,
	output cache_geom_pkg::word_t      proc_rdata,
	output logic                       hit,
	output logic                       victim_valid,
	output cache_geom_pkg::line_addr_t victim_addr,
	output cache_geom_pkg::line_t      victim_line,
	input  logic                       access,
	input  logic                       fill,
	input  cache_geom_pkg::line_t      mem_rdata
);
	import cache_geom_pkg::*;

	localparam int IDX_W = $clog2(NUM_SETS);
	localparam int TAG_W = $bits(line_addr_t) - IDX_W;

	typedef logic [IDX_W-1:0] idx_t;
	typedef logic [TAG_W-1:0] tag_t;

	// ------------------------------------------------------------------------
	// arrays, two ways per set
	// ------------------------------------------------------------------------
	tag_t                      tag_q  [NUM_SETS][2];
	line_t                     data_q [NUM_SETS][2];
	logic [NUM_SETS-1:0][1:0]  valid_q;
	logic [NUM_SETS-1:0]       lru_q;  // names the least recently used way

	line_addr_t req_line;
	word_off_t  req_off;
	idx_t       req_idx;
	tag_t       req_tag;
	logic [1:0] hit_way;
	logic       hit_sel;  // way that hit
	logic       vic_way;  // way picked for replacement
	line_t      hit_line;
	line_t      wr_line;

	// ------------------------------------------------------------------------
	// address split
	// ------------------------------------------------------------------------
	assign req_line = proc_req.addr[$bits(word_addr_t)-1:$bits(word_off_t)];
	assign req_off  = proc_req.addr[$bits(word_off_t)-1:0];
	assign req_idx  = req_line[IDX_W-1:0];
	assign req_tag  = req_line[$bits(line_addr_t)-1:IDX_W];

	// ------------------------------------------------------------------------
	// lookup
	// ------------------------------------------------------------------------
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			hit_way[w] = valid_q[req_idx][w] && (tag_q[req_idx][w] == req_tag);
		end
	end

	assign hit      = |hit_way;
	assign hit_sel  = hit_way[1];
	assign hit_line = data_q[req_idx][hit_sel];

	// only meaningful while hit is high
	assign proc_rdata = hit_line[req_off*WORD_BITS +: WORD_BITS];

	// merge the write word into the hit line
	always_comb begin
		wr_line = hit_line;
		for (int i = 0; i < WORDS_PER_LINE; i++) begin
			if (word_off_t'(i) == req_off) begin
				wr_line[i*WORD_BITS +: WORD_BITS] = proc_req.wdata;
			end
		end
	end

	// ------------------------------------------------------------------------
	// victim choice
	// ------------------------------------------------------------------------
	// empty way first, then LRU; stays put while the miss is served since
	// the arrays only change on fill
	always_comb begin
		if (!valid_q[req_idx][0]) begin
			vic_way = 1'b0;
		end else if (!valid_q[req_idx][1]) begin
			vic_way = 1'b1;
		end else begin
			vic_way = lru_q[req_idx];
		end
	end

	assign victim_valid = valid_q[req_idx][vic_way];
	assign victim_addr  = {tag_q[req_idx][vic_way], req_idx};  // same set as the request
	assign victim_line  = data_q[req_idx][vic_way];

	// ------------------------------------------------------------------------
	// state updates
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
			lru_q   <= '0;
		end else begin
			if (fill) begin
				valid_q[req_idx][vic_way] <= 1'b1;
			end
			if (access) begin
				lru_q[req_idx] <= ~hit_sel;  // the other way is now older
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill) begin
			data_q[req_idx][vic_way] <= mem_rdata;
			tag_q[req_idx][vic_way]  <= req_tag;
		end else if (access && proc_req.write) begin
			data_q[req_idx][hit_sel] <= wr_line;
		end
	end

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	// controller strobes are exclusive
	a_fill_access_excl: assert property (
		@(posedge clk) disable iff (!rst_n) !(fill && access)
	);

	// a fill never duplicates a line already resident in the other way
	a_single_way_hit: assert property (
		@(posedge clk) disable iff (!rst_n) !(&hit_way)
	);

endmodule

`default_nettype wire

// File: design/cache_bus_pkg.sv
// port structs only; read and write must never be high together on either port
`default_nettype none

package cache_bus_pkg;

	// ------------------------------------------------------------------------
	// processor port, 64 bits
	// held unchanged by the requester while stall is high
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic                       read;
		logic                       write;
		cache_geom_pkg::word_addr_t addr;
		cache_geom_pkg::word_t      wdata;  // ignored on reads
	} proc_req_t;

	// ------------------------------------------------------------------------
	// memory port, 158 bits
	// held by the cache until a one-cycle mem_ready
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic                       read;
		logic                       write;
		cache_geom_pkg::line_addr_t addr;
		cache_geom_pkg::line_t      wdata;  // victim line on write-back
	} mem_req_t;

endpackage

`default_nettype wire

// File: design/cache_geom_pkg.sv
// fixed line geometry: 32-bit words, four words per line, 30-bit word address, no byte enables
`default_nettype none

package cache_geom_pkg;

	// ------------------------------------------------------------------------
	// word and line sizes
	// ------------------------------------------------------------------------
	localparam int WORD_BITS      = 32;
	localparam int WORDS_PER_LINE = 4;

	typedef logic [WORD_BITS-1:0] word_t;  // one data word

	// word 0 sits in the low bits
	typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;

	// ------------------------------------------------------------------------
	// addresses
	// ------------------------------------------------------------------------
	typedef logic [29:0] word_addr_t;  // processor side, word granular

	// word position inside a line
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_off_t;

	// memory side, the word address minus its offset
	typedef logic [$bits(word_addr_t)-$bits(word_off_t)-1:0] line_addr_t;

endpackage

`default_nettype wire
